//--- logic/ps2_pkg.sv
/*
  shared constants and packed structs for the PS/2 keyboard host
  the release structure follows the open-drain pad convention, a 1 lets
  the board pull-up float the line high and a 0 drives it low
*/
`default_nettype none

package ps2_pkg;

  // ------------------------------------------------------------------
  // frame layout and special codes
  // ------------------------------------------------------------------

  // start bit, eight data bits, odd parity and stop bit
  localparam int unsigned FRAME_BITS = 11;

  // prefix that the keyboard sends ahead of a key release
  localparam logic [7:0] RELEASE_CODE = 8'hF0;

  // ------------------------------------------------------------------
  // structs that travel between the blocks
  // ------------------------------------------------------------------

  // synchronized levels of the two PS/2 lines
  typedef struct packed {
    logic clk;
    logic data;
  } ps2_lines_t;

  // one-cycle pulses on the synchronized PS/2 clock
  typedef struct packed {
    logic fall;
    logic rise;
  } ps2_edges_t;

  // received byte with its one-cycle done strobe
  typedef struct packed {
    logic [7:0] data;
    logic       done;
  } rx_frame_t;

  // host side of each wired-AND line
  typedef struct packed {
    logic clk_release;
    logic data_release;
  } ps2_release_t;

endpackage

`default_nettype wire

//--- logic/ps2_line_sync.sv
/*
  brings the PS/2 clock and data pins into the clk domain
  lines_o lags the pins by two cycles, edge pulses line up with lines_o
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_line_sync
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_i,
  input  logic       ps2_data_i,
  output ps2_lines_t lines_o,
  output ps2_edges_t edges_o
);

  ps2_lines_t meta_q;
  // delayed copy of the synchronized clock, used only for edge detection
  logic       clk_last_q;

  // both stages reset high since an idle PS/2 line sits at the pull-up
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      meta_q     <= '{clk: 1'b1, data: 1'b1};
      lines_o    <= '{clk: 1'b1, data: 1'b1};
      clk_last_q <= 1'b1;
    end
    else
    begin
      meta_q     <= '{clk: ps2_clk_i, data: ps2_data_i};
      lines_o    <= meta_q;
      clk_last_q <= lines_o.clk;
    end
  end

  // edges come in the same cycle as the changed level on lines_o
  assign edges_o.fall = clk_last_q & ~lines_o.clk;
  assign edges_o.rise = ~clk_last_q & lines_o.clk;

endmodule

`default_nettype wire

//--- logic/ps2_interval_timer.sv
/*
  cycle counter for fixed intervals, LIMIT must be at least 1
  the count restarts from zero whenever enable_i drops
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_interval_timer #(
  parameter int unsigned LIMIT = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic enable_i,
  output logic done_o
);

  localparam int unsigned CW = $clog2(LIMIT + 1);

  logic [CW-1:0] count_q;

  // counting stops at LIMIT so done holds for as long as enable stays up
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      count_q <= '0;
    else if (!enable_i)
      count_q <= '0;
    else if (!done_o)
      count_q <= count_q + 1'b1;
  end

  assign done_o = (count_q == CW'(LIMIT));

endmodule

`default_nettype wire

//--- logic/ps2_frame_receiver.sv
/*
  serial to parallel side of the keyboard link
  no parity or start/stop check is made on received frames
  a clock line that stays high for T60_CYCLES drops a partial frame, so a
  keyboard can be plugged in while the host runs
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_frame_receiver
  import ps2_pkg::*;
#(
  parameter int unsigned T60_CYCLES = 2950
) (
  input  logic       clk,
  input  logic       reset,
  input  ps2_lines_t lines_i,
  input  ps2_edges_t edges_i,
  input  logic       tx_busy_i,
  output rx_frame_t  frame_o
);

  localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS);

  logic [FRAME_BITS-1:0] shift_q;
  logic [3:0]            bit_count_q;
  logic                  watchdog_done;
  logic                  frame_full;

  // ------------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------------

  // runs only while the keyboard clock is high, any low clock restarts it
  ps2_interval_timer #(
    .LIMIT (T60_CYCLES)
  ) i_watchdog (
    .clk      (clk),
    .reset    (reset),
    .enable_i (lines_i.clk),
    .done_o   (watchdog_done)
  );

  // ------------------------------------------------------------------
  // bit counter and shift register
  // ------------------------------------------------------------------

  // high for the single cycle after the fall that takes in the 11th bit
  assign frame_full = (bit_count_q == LAST_BIT);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bit_count_q <= '0;
      shift_q     <= '0;
    end
    else if (tx_busy_i)
    begin
      // the transmitter owns the lines, anything half received is lost
      bit_count_q <= '0;
      shift_q     <= '0;
    end
    else if (frame_full)
      bit_count_q <= '0;
    else if (edges_i.fall)
    begin
      // LSB first on the wire, so new bits enter at the top
      shift_q     <= {lines_i.data, shift_q[FRAME_BITS-1:1]};
      // a fall that ends a long high clock is the start bit of a new frame
      bit_count_q <= watchdog_done ? 4'd1 : bit_count_q + 4'd1;
    end
    else if (watchdog_done)
      bit_count_q <= '0;
  end

  // bit 0 holds the start bit, bits 8:1 the data byte
  assign frame_o.data = shift_q[8:1];
  assign frame_o.done = frame_full;

endmodule

`default_nettype wire

//--- logic/ps2_scan_decoder.sv
/*
  release-prefix handling and the host-facing receive registers
  there is no queue, a byte arriving before rx_read_i overwrites the last
  with translate_i low every byte, F0 included, is reported as it comes
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_scan_decoder
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  rx_frame_t  frame_i,
  input  logic       translate_i,
  input  logic       rx_read_i,
  output logic [7:0] rx_scan_code_o,
  output logic       rx_released_o,
  output logic       rx_data_ready_o
);

  logic is_release;
  logic out_strobe;
  // a release prefix was seen and waits for the key code that follows
  logic hold_released_q;

  assign is_release = translate_i && (frame_i.data == RELEASE_CODE);
  assign out_strobe = frame_i.done && !is_release;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hold_released_q <= 1'b0;
      rx_released_o   <= 1'b0;
      rx_data_ready_o <= 1'b0;
    end
    else
    begin
      if (frame_i.done && is_release)
        hold_released_q <= 1'b1;
      else if (out_strobe)
        hold_released_q <= 1'b0;

      if (out_strobe)
        rx_released_o <= hold_released_q;

      // a new byte wins over a read landing in the same cycle
      if (out_strobe)
        rx_data_ready_o <= 1'b1;
      else if (rx_read_i)
        rx_data_ready_o <= 1'b0;
    end
  end

  // scan code register only ever changes together with ready
  always_ff @(posedge clk)
  begin
    if (out_strobe)
      rx_scan_code_o <= frame_i.data;
  end

endmodule

`default_nettype wire

//--- logic/ps2_host_transmitter.sv
/*
  host to keyboard command path, one byte per transmit
  a write is taken only while idle, the source holds tx_write_i until ack
  the keyboard takes each bit at its clock fall and answers the stop bit
  by pulling data low before the next fall, a high there is a missing ack
  a keyboard that stops clocking leaves the FSM waiting, there is no timeout
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_host_transmitter
  import ps2_pkg::*;
#(
  parameter int unsigned T60_CYCLES      = 2950,
  parameter int unsigned DEBOUNCE_CYCLES = 186
) (
  input  logic         clk,
  input  logic         reset,
  input  ps2_lines_t   lines_i,
  input  ps2_edges_t   edges_i,
  input  logic [7:0]   tx_data_i,
  input  logic         tx_write_i,
  output logic         tx_write_ack_o,
  output logic         tx_busy_o,
  output logic         tx_error_o,
  output ps2_release_t line_drive_o
);

  // bits still to go out after the start bit
  localparam logic [3:0] TX_BITS = 4'(FRAME_BITS - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_INHIBIT,
    ST_START,
    ST_BIT_LOW,
    ST_BIT_HIGH,
    ST_ACK_WAIT,
    ST_DONE_OK,
    ST_NO_ACK
  } tx_state_e;

  tx_state_e             state_q;
  logic [FRAME_BITS-1:0] shift_q;
  logic [3:0]            bit_count_q;
  logic                  inhibit_done;
  logic                  debounce_en;
  logic                  debounce_done;

  // ------------------------------------------------------------------
  // timers
  // ------------------------------------------------------------------

  ps2_interval_timer #(
    .LIMIT (T60_CYCLES)
  ) i_inhibit_timer (
    .clk      (clk),
    .reset    (reset),
    .enable_i (state_q == ST_INHIBIT),
    .done_o   (inhibit_done)
  );

  // in START it covers the pull-up rise plus the sync delay after the
  // clock is let go, in BIT_LOW it asks for a clock that stays high
  assign debounce_en = (state_q == ST_START) ||
                       ((state_q == ST_BIT_LOW) && lines_i.clk);

  ps2_interval_timer #(
    .LIMIT (DEBOUNCE_CYCLES)
  ) i_debounce_timer (
    .clk      (clk),
    .reset    (reset),
    .enable_i (debounce_en),
    .done_o   (debounce_done)
  );

  // ------------------------------------------------------------------
  // FSM, shift register and bit counter
  // ------------------------------------------------------------------

  assign tx_write_ack_o = tx_write_i && (state_q == ST_IDLE);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q     <= ST_IDLE;
      shift_q     <= '1;
      bit_count_q <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (tx_write_ack_o)
          begin
            // stop, odd parity, data, start with the start bit at bit 0
            shift_q     <= {1'b1, ~^tx_data_i, tx_data_i, 1'b0};
            bit_count_q <= '0;
            state_q     <= ST_INHIBIT;
          end
        end
        ST_INHIBIT:
        begin
          if (inhibit_done)
            state_q <= ST_START;
        end
        ST_START:
        begin
          // the keyboard starts clocking once it sees the start bit
          if (debounce_done && !lines_i.clk)
            state_q <= ST_BIT_LOW;
        end
        ST_BIT_LOW:
        begin
          // next bit goes out once the rising clock has settled
          if (debounce_done)
          begin
            shift_q     <= {1'b1, shift_q[FRAME_BITS-1:1]};
            bit_count_q <= bit_count_q + 4'd1;
            state_q     <= ST_BIT_HIGH;
          end
        end
        ST_BIT_HIGH:
        begin
          // the fall that takes the stop bit moves on to the ack
          if (edges_i.fall)
            state_q <= (bit_count_q == TX_BITS) ? ST_ACK_WAIT : ST_BIT_LOW;
        end
        ST_ACK_WAIT:
        begin
          if (edges_i.fall)
            state_q <= lines_i.data ? ST_NO_ACK : ST_DONE_OK;
        end
        ST_DONE_OK,
        ST_NO_ACK:
        begin
          // recovery ends with both lines back at the pull-up
          if (lines_i.clk && lines_i.data)
            state_q <= ST_IDLE;
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------

  assign tx_busy_o  = (state_q != ST_IDLE);
  assign tx_error_o = (state_q == ST_NO_ACK);

  assign line_drive_o.clk_release = (state_q != ST_INHIBIT);

  // shift_q[0] is the start bit in START and the current bit afterwards
  always_comb
  begin
    case (state_q)
      ST_START,
      ST_BIT_LOW,
      ST_BIT_HIGH:
        line_drive_o.data_release = shift_q[0];
      default:
        line_drive_o.data_release = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/ps2_kbd_top.sv
/*
  PS/2 keyboard host with receive and command transmit paths
  each PS/2 pin is a wired-AND of pull-up, host and keyboard, the release
  outputs drive an open-drain pad low when 0 and float it when 1
  T60_CYCLES is 60 us in clk cycles and must exceed a keyboard clock period
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_top
  import ps2_pkg::*;
#(
  parameter int unsigned T60_CYCLES      = 2950,
  parameter int unsigned DEBOUNCE_CYCLES = 186
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_i,
  input  logic       ps2_data_i,
  output logic       ps2_clk_release_o,
  output logic       ps2_data_release_o,
  output logic [7:0] rx_scan_code_o,
  output logic       rx_released_o,
  output logic       rx_data_ready_o,
  input  logic       rx_read_i,
  input  logic [7:0] tx_data_i,
  input  logic       tx_write_i,
  output logic       tx_write_ack_o,
  output logic       tx_error_o,
  input  logic       translate_i
);

  ps2_lines_t   lines;
  ps2_edges_t   edges;
  rx_frame_t    frame;
  ps2_release_t line_drive;
  // the transmitter owns both lines while this is high
  logic         tx_busy;

  ps2_line_sync i_line_sync (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk_i  (ps2_clk_i),
    .ps2_data_i (ps2_data_i),
    .lines_o    (lines),
    .edges_o    (edges)
  );

  ps2_frame_receiver #(
    .T60_CYCLES (T60_CYCLES)
  ) i_frame_receiver (
    .clk       (clk),
    .reset     (reset),
    .lines_i   (lines),
    .edges_i   (edges),
    .tx_busy_i (tx_busy),
    .frame_o   (frame)
  );

  ps2_scan_decoder i_scan_decoder (
    .clk             (clk),
    .reset           (reset),
    .frame_i         (frame),
    .translate_i     (translate_i),
    .rx_read_i       (rx_read_i),
    .rx_scan_code_o  (rx_scan_code_o),
    .rx_released_o   (rx_released_o),
    .rx_data_ready_o (rx_data_ready_o)
  );

  ps2_host_transmitter #(
    .T60_CYCLES      (T60_CYCLES),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) i_host_transmitter (
    .clk            (clk),
    .reset          (reset),
    .lines_i        (lines),
    .edges_i        (edges),
    .tx_data_i      (tx_data_i),
    .tx_write_i     (tx_write_i),
    .tx_write_ack_o (tx_write_ack_o),
    .tx_busy_o      (tx_busy),
    .tx_error_o     (tx_error_o),
    .line_drive_o   (line_drive)
  );

  assign ps2_clk_release_o  = line_drive.clk_release;
  assign ps2_data_release_o = line_drive.data_release;

endmodule

`default_nettype wire

//--- dv/ps2_kbd_assertions.sv
/*
  protocol checks bound into ps2_kbd_top
  tx_busy_i comes from the internal transmitter busy level
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_assertions (
  input logic clk,
  input logic reset,
  input logic clk_release_i,
  input logic data_release_i,
  input logic ready_i,
  input logic read_i,
  input logic error_i,
  input logic write_ack_i,
  input logic tx_busy_i
);

  // ready only falls through a read, a new byte keeps it up
  ready_holds: assert property (@(posedge clk) disable iff (reset)
    ready_i && !read_i |=> ready_i)
  else
    $error("rx_data_ready_o fell without rx_read_i");

  // both lines float and no error shows once reset lets go
  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> clk_release_i && data_release_i && !error_i)
  else
    $error("line release or tx_error wrong after reset");

  // an acked write is taken at once, so the transmitter is busy next cycle
  ack_when_idle: assert property (@(posedge clk) disable iff (reset)
    write_ack_i |=> tx_busy_i)
  else
    $error("transmitter not busy after tx_write_ack_o");

endmodule

bind ps2_kbd_top ps2_kbd_assertions i_assertions (
  .clk            (clk),
  .reset          (reset),
  .clk_release_i  (ps2_clk_release_o),
  .data_release_i (ps2_data_release_o),
  .ready_i        (rx_data_ready_o),
  .read_i         (rx_read_i),
  .error_i        (tx_error_o),
  .write_ack_i    (tx_write_ack_o),
  .tx_busy_i      (tx_busy)
);

`default_nettype wire

//--- dv/ps2_kbd_tb.sv
/*
  testbench for the PS/2 keyboard host with a keyboard model on both lines
  the model clocks at 16 cycles per bit, so the DUT gets scaled timer limits
  each line is the wired-AND of the DUT release output and the model drive
*/
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_tb
  import ps2_pkg::*;
();

  localparam int unsigned T60_CYCLES      = 40;
  localparam int unsigned DEBOUNCE_CYCLES = 4;
  localparam int HALF_CYCLES  = 8;
  // one frame in either direction plus the ack bit and a tail
  localparam int FRAME_CYCLES = (FRAME_BITS + 2) * 2 * HALF_CYCLES;
  localparam int RUN_FRAMES   = 8;
  localparam int RUN_LIMIT    = RUN_FRAMES * (FRAME_CYCLES + T60_CYCLES) + 500;

  logic       clk;
  logic       reset;
  logic       kbd_clk;
  logic       kbd_data;
  logic       ps2_clk;
  logic       ps2_data;
  logic       clk_release;
  logic       data_release;
  logic [7:0] rx_scan_code;
  logic       rx_released;
  logic       rx_data_ready;
  logic       rx_read;
  logic [7:0] tx_data;
  logic       tx_write;
  logic       tx_write_ack;
  logic       tx_error;
  logic       translate;

  // expectations that the stimulus and the keyboard model record
  logic [7:0]  exp_code;
  logic        exp_released;
  logic        ready_expected;
  logic [10:0] host_bits;
  logic [10:0] exp_host_bits;
  logic        host_seen;
  logic        expect_ack;
  logic        expect_no_ack;
  logic [31:0] rng_state;
  int          errors;
  int          errors_before;
  int          tests_run;
  int          tests_failed;

  assign ps2_clk  = clk_release & kbd_clk;
  assign ps2_data = data_release & kbd_data;

  ps2_kbd_top #(
    .T60_CYCLES      (T60_CYCLES),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) i_dut (
    .clk                (clk),
    .reset              (reset),
    .ps2_clk_i          (ps2_clk),
    .ps2_data_i         (ps2_data),
    .ps2_clk_release_o  (clk_release),
    .ps2_data_release_o (data_release),
    .rx_scan_code_o     (rx_scan_code),
    .rx_released_o      (rx_released),
    .rx_data_ready_o    (rx_data_ready),
    .rx_read_i          (rx_read),
    .tx_data_i          (tx_data),
    .tx_write_i         (tx_write),
    .tx_write_ack_o     (tx_write_ack),
    .tx_error_o         (tx_error),
    .translate_i        (translate)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  assert property (@(posedge clk) $fell(reset) |->
    clk_release && data_release && !rx_data_ready && !tx_error)
  else
  begin
    errors++;
    $display("mismatch at %0t ns: outputs not at their reset values", $time);
  end

  // a ready that nobody asked for means a release prefix leaked through
  assert property (@(posedge clk) disable iff (reset)
    $rose(rx_data_ready) |-> ready_expected)
  else
  begin
    errors++;
    $display("mismatch at %0t ns: ready rose for code %h", $time, rx_scan_code);
  end

  assert property (@(posedge clk) disable iff (reset)
    $rose(rx_data_ready) |-> rx_scan_code == exp_code && rx_released == exp_released)
  else
  begin
    errors++;
    $display("mismatch at %0t ns: code %h released %b, expected %h released %b",
             $time, rx_scan_code, rx_released, exp_code, exp_released);
  end

  assert property (@(posedge clk) disable iff (reset) rx_read |=> !rx_data_ready)
  else
  begin
    errors++;
    $display("mismatch at %0t ns: ready still high after a read", $time);
  end

  assert property (@(posedge clk) host_seen |-> host_bits == exp_host_bits)
  else
  begin
    errors++;
    $display("mismatch at %0t ns: keyboard got frame %h, expected %h",
             $time, host_bits, exp_host_bits);
  end

  assert property (@(posedge clk) disable iff (reset) expect_ack |-> !tx_error)
  else
  begin
    errors++;
    $display("mismatch at %0t ns: tx_error high on an acked transmit", $time);
  end

  // busy can only fall out of NO_ACK or DONE_OK, so the cycle before tells which
  assert property (@(posedge clk) disable iff (reset)
    expect_no_ack && $fell(i_dut.tx_busy) |-> $past(tx_error))
  else
  begin
    errors++;
    $display("mismatch at %0t ns: transmit ended without tx_error", $time);
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // stop, odd parity, data LSB first, start at bit 0
  function automatic logic [10:0] frame_of(input logic [7:0] b);
    return {1'b1, ~(^b), b, 1'b0};
  endfunction

  task automatic random_byte(output logic [7:0] b);
    rng_state = xorshift32(rng_state);
    b = rng_state[15:8];
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%0t ns: %s", $time, msg);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != errors_before)
      tests_failed++;
    $display("test %0d %s: %s", tests_run, name,
             (errors == errors_before) ? "passed" : "failed");
    errors_before = errors;
  endtask

  // the keyboard changes data mid high phase and the host samples at the fall
  task automatic kbd_send_bits(input logic [10:0] bits, input int count);
    logic [10:0] s;
    s = bits;
    repeat (count)
    begin
      kbd_data = s[0];
      s = s >> 1;
      wait_cycles(HALF_CYCLES);
      kbd_clk = 1'b0;
      wait_cycles(HALF_CYCLES);
      kbd_clk = 1'b1;
    end
    kbd_data = 1'b1;
  endtask

  task automatic kbd_send_byte(input logic [7:0] b);
    kbd_send_bits(frame_of(b), FRAME_BITS);
    wait_cycles(HALF_CYCLES);
  endtask

  // the model takes each host bit at its own clock fall, then gives the ack bit
  task automatic kbd_take_host_frame(input logic ack);
    int n;
    n = 0;
    while (ps2_clk && n < 4 * T60_CYCLES)
    begin
      @(negedge clk);
      n++;
    end
    while (!(ps2_clk && !ps2_data) && n < 8 * T60_CYCLES)
    begin
      @(negedge clk);
      n++;
    end
    if (n >= 8 * T60_CYCLES)
    begin
      note_failure("host never released the clock with a start bit");
      return;
    end
    wait_cycles(HALF_CYCLES);
    repeat (FRAME_BITS)
    begin
      kbd_clk = 1'b0;
      host_bits = {ps2_data, host_bits[10:1]};
      wait_cycles(HALF_CYCLES);
      kbd_clk = 1'b1;
      wait_cycles(HALF_CYCLES);
    end
    host_seen = 1'b1;
    kbd_data  = !ack;
    wait_cycles(HALF_CYCLES / 2);
    host_seen = 1'b0;
    kbd_clk   = 1'b0;
    wait_cycles(HALF_CYCLES);
    kbd_clk   = 1'b1;
    kbd_data  = 1'b1;
    wait_cycles(HALF_CYCLES);
  endtask

  task automatic host_write(input logic [7:0] b);
    int n;
    n = 0;
    tx_data  = b;
    tx_write = 1'b1;
    @(negedge clk);
    while (!tx_write_ack && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (!tx_write_ack)
      note_failure("write was never acknowledged");
    wait_cycles(1);
    tx_write = 1'b0;
  endtask

  task automatic transmit(input logic [7:0] b, input logic ack);
    int n;
    n = 0;
    exp_host_bits = frame_of(b);
    host_write(b);
    kbd_take_host_frame(ack);
    while (i_dut.tx_busy && n < FRAME_CYCLES)
    begin
      @(negedge clk);
      n++;
    end
    if (i_dut.tx_busy)
      note_failure("transmit never returned to idle");
    wait_cycles(1);
  endtask

  // holds ready for a few cycles before the read so the hold is exercised
  task automatic read_byte(input string what);
    int n;
    n = 0;
    while (!rx_data_ready && n < FRAME_CYCLES)
    begin
      @(negedge clk);
      n++;
    end
    if (!rx_data_ready)
      note_failure({"no data ready for ", what});
    wait_cycles(3);
    rx_read = 1'b1;
    wait_cycles(1);
    rx_read = 1'b0;
    ready_expected = 1'b0;
    wait_cycles(1);
  endtask

  // ------------------------------------------------------------------
  // watchdog and stimulus
  // ------------------------------------------------------------------

  initial
  begin
    #(RUN_LIMIT * 10);
    $display("run stopped by the watchdog after %0d cycles", RUN_LIMIT);
    $display("Errors found");
    $finish;
  end

  initial
  begin
    logic [7:0] b;
    clk            = 1'b0;
    reset          = 1'b1;
    kbd_clk        = 1'b1;
    kbd_data       = 1'b1;
    rx_read        = 1'b0;
    tx_data        = 8'h00;
    tx_write       = 1'b0;
    translate      = 1'b0;
    exp_code       = 8'h00;
    exp_released   = 1'b0;
    ready_expected = 1'b0;
    host_bits      = '1;
    exp_host_bits  = '1;
    host_seen      = 1'b0;
    expect_ack     = 1'b0;
    expect_no_ack  = 1'b0;
    rng_state      = 32'hac9006af;
    errors         = 0;
    errors_before  = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycles(2);
    finish_test("reset values");

    random_byte(b);
    exp_code       = b;
    exp_released   = 1'b0;
    ready_expected = 1'b1;
    kbd_send_byte(b);
    read_byte("a random byte");
    finish_test("random scan byte");

    // F0 with translation on only marks the next byte as a release
    translate = 1'b1;
    random_byte(b);
    if (b == RELEASE_CODE)
      b = 8'h1c;
    exp_code     = b;
    exp_released = 1'b1;
    kbd_send_byte(RELEASE_CODE);
    ready_expected = 1'b1;
    kbd_send_byte(b);
    read_byte("a released key");
    translate      = 1'b0;
    exp_code       = RELEASE_CODE;
    exp_released   = 1'b0;
    ready_expected = 1'b1;
    kbd_send_byte(RELEASE_CODE);
    read_byte("F0 with translation off");
    finish_test("release prefix");

    random_byte(b);
    expect_ack = 1'b1;
    transmit(b, 1'b1);
    expect_ack = 1'b0;
    finish_test("command with ack");

    random_byte(b);
    expect_no_ack = 1'b1;
    transmit(b, 1'b0);
    expect_no_ack = 1'b0;
    finish_test("command without ack");

    // four bits of junk, a long idle clock, then a clean frame
    random_byte(b);
    kbd_send_bits(frame_of(~b), 4);
    wait_cycles(T60_CYCLES + 2 * HALF_CYCLES);
    exp_code       = b;
    exp_released   = 1'b0;
    ready_expected = 1'b1;
    kbd_send_byte(b);
    read_byte("the frame after a cut-off frame");
    finish_test("receive watchdog");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
logic/ps2_pkg.sv
logic/ps2_line_sync.sv
logic/ps2_interval_timer.sv
logic/ps2_frame_receiver.sv
logic/ps2_scan_decoder.sv
logic/ps2_host_transmitter.sv
logic/ps2_kbd_top.sv
dv/ps2_kbd_assertions.sv
dv/ps2_kbd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the PS/2 keyboard host testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module ps2_kbd_tb -Mdir obj_dir -f sources.f

sim_out="$(./obj_dir/Vps2_kbd_tb 2>&1)" || true
printf '%s\n' "$sim_out"

# the run passes only if the pass line shows up
grep -qx "No errors" <<< "$sim_out"
